//--- flist.f
logic/energy_pkg.sv
logic/bp_pipe.sv
logic/row_sequencer.sv
logic/partial_energy_calc.sv
logic/energy_accumulator.sv
logic/energy_monitor.sv
bench/tb_energy_monitor.sv

//--- Bender.yml
package:
  name: energy_monitor

sources:
  # Package first, then leaf blocks, then the top level
  - logic/energy_pkg.sv
  - logic/bp_pipe.sv
  - logic/row_sequencer.sv
  - logic/partial_energy_calc.sv
  - logic/energy_accumulator.sv
  - logic/energy_monitor.sv

  # Testbench only in test builds
  - target: test
    files:
      - bench/tb_energy_monitor.sv

//--- bench/tb_energy_monitor.sv
// Testbench for the Ising energy monitor
// Runs a table of jobs through config, spin and weight channels
// Each result is compared with a row-by-row energy model
// Inputs change and outputs are sampled on the falling edge

`default_nettype none

module tb_energy_monitor
    import energy_pkg::*;
();

    localparam int TIMEOUT   = 200;
    localparam int NUM_CASES = 8;

    // One job of the stimulus table
    typedef struct packed {
        int        start;
        spin_vec_t spins;
        int        coup;
        int        bias;
        int        scale;
        bit        rnd;
        bit        stall;
    } case_t;

    // Random cases ignore the fixed spin, coupling, bias and scale fields
    case_t cases [NUM_CASES] = '{
        '{0, 16'hFFFF,  1,  1, 1, 1'b0, 1'b0},
        '{0, 16'h0000,  1,  1, 1, 1'b0, 1'b0},
        '{0, 16'hFFFF, -1,  1, 1, 1'b0, 1'b0},
        '{0, 16'hFFFF,  7,  7, 7, 1'b0, 1'b0},
        '{6, 16'hA5C3,  3, -2, 5, 1'b0, 1'b0},
        '{0, 16'h0000,  0,  0, 0, 1'b1, 1'b0},
        '{4, 16'h0000,  0,  0, 0, 1'b1, 1'b1},
        '{0, 16'h0000,  0,  0, 0, 1'b1, 1'b1}
    };

    logic         clk_i;
    logic         arst_n_i;
    logic         config_valid_i;
    spin_idx_t    config_i;
    logic         config_ready_o;
    logic         spin_valid_i;
    spin_vec_t    spin_i;
    logic         spin_ready_o;
    logic         weight_valid_i;
    weight_beat_t weight_i;
    logic         weight_ready_o;
    logic         energy_valid_o;
    energy_t      energy_o;
    logic         energy_ready_i;

    // Model copy of the current job's matrix, biases and scales
    int jm [NUM_SPIN][NUM_SPIN];
    int hb [NUM_SPIN];
    int sc [NUM_SPIN];

    energy_monitor energy_monitor_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input logic signed [31:0] got, input logic signed [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at time %0t: %s got %0d expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at time %0t: %s did not finish within %0d cycles",
                 $time, what, TIMEOUT);
        abort_run();
    endtask

    // Row r adds s_r * (sum_j J_rj*s_j + h_r*scale_r) with spin 0 as -1
    function automatic int expected_energy(input int start, input spin_vec_t s);
        int total;
        int field;
        total = 0;
        for (int r = start; r < NUM_SPIN; r++) begin
            field = hb[r] * sc[r];
            for (int j = 0; j < NUM_SPIN; j++) begin
                field = s[j] ? field + jm[r][j] : field - jm[r][j];
            end
            total = s[r] ? total + field : total - field;
        end
        return total;
    endfunction

    // All senders start and end on a falling edge
    task automatic send_config(input int start);
        int waited;
        waited = 0;
        config_i       = spin_idx_t'(start);
        config_valid_i = 1'b1;
        while (!config_ready_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) report_timeout("config transfer");
        end
        // Transfer happens on the rising edge in between
        @(negedge clk_i);
        config_valid_i = 1'b0;
    endtask

    task automatic send_spin(input spin_vec_t v, input int gap);
        int waited;
        waited = 0;
        repeat (gap) @(negedge clk_i);
        spin_i       = v;
        spin_valid_i = 1'b1;
        while (!spin_ready_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) report_timeout("spin transfer");
        end
        @(negedge clk_i);
        spin_valid_i = 1'b0;
    endtask

    task automatic send_beat(input weight_beat_t beat, input int gap);
        int waited;
        waited = 0;
        repeat (gap) @(negedge clk_i);
        weight_i       = beat;
        weight_valid_i = 1'b1;
        while (!weight_ready_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) report_timeout("weight transfer");
        end
        @(negedge clk_i);
        weight_valid_i = 1'b0;
    endtask

    // Wait for the total, optionally stall the consumer, then take it
    task automatic collect_energy(input int exp, input int stall, input int idx);
        int waited;
        waited = 0;
        while (!energy_valid_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) report_timeout("energy result");
        end
        check_value(energy_o, exp, $sformatf("case %0d energy", idx));
        repeat (stall) begin
            @(negedge clk_i);
            check_value(energy_valid_o, 1, $sformatf("case %0d valid hold", idx));
            check_value(energy_o, exp, $sformatf("case %0d energy hold", idx));
            check_value(weight_ready_o, 0, $sformatf("case %0d weight ready", idx));
        end
        energy_ready_i = 1'b1;
        @(negedge clk_i);
        energy_ready_i = 1'b0;
        // Taking the result clears the total
        check_value(energy_valid_o, 0, $sformatf("case %0d valid clear", idx));
        check_value(energy_o, 0, $sformatf("case %0d total clear", idx));
    endtask

    initial begin
        case_t        c;
        spin_vec_t    spins;
        weight_beat_t beat;
        int           exp;
        int           r;
        void'($urandom(32'h841a));
        arst_n_i       = 1'b0;
        config_valid_i = 1'b0;
        config_i       = '0;
        spin_valid_i   = 1'b0;
        spin_i         = '0;
        weight_valid_i = 1'b0;
        weight_i       = '0;
        energy_ready_i = 1'b0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        // Nothing may be ready before the first clock after release
        check_value(energy_valid_o, 0, "energy valid after reset");
        check_value(config_ready_o, 0, "config ready after reset");
        check_value(spin_ready_o, 0, "spin ready after reset");
        check_value(weight_ready_o, 0, "weight ready after reset");

        for (int i = 0; i < NUM_CASES; i++) begin
            c     = cases[i];
            spins = c.rnd ? spin_vec_t'($urandom) : c.spins;
            for (int row = 0; row < NUM_SPIN; row++) begin
                for (int j = 0; j < NUM_SPIN; j++) begin
                    jm[row][j] = c.rnd ? int'($urandom_range(15)) - 8 : c.coup;
                end
                hb[row] = c.rnd ? int'($urandom_range(15)) - 8 : c.bias;
                sc[row] = c.rnd ? int'($urandom_range(7)) : c.scale;
            end
            exp = expected_energy(c.start, spins);

            send_config(c.start);
            send_spin(spins, c.rnd ? int'($urandom_range(3)) : 0);
            for (int b = 0; b < (NUM_SPIN - c.start) / PARALLELISM; b++) begin
                beat = '0;
                for (int p = 0; p < PARALLELISM; p++) begin
                    r = c.start + b * PARALLELISM + p;
                    for (int j = 0; j < NUM_SPIN; j++) begin
                        beat[p].row[j] = BIT_J'(jm[r][j]);
                    end
                    beat[p].hbias    = BIT_H'(hb[r]);
                    beat[p].hscaling = SCALING_BIT'(sc[r]);
                end
                send_beat(beat, c.rnd ? int'($urandom_range(3)) : 0);
            end
            collect_energy(exp, c.stall ? int'($urandom_range(8, 1)) : 0, i);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/energy_monitor.sv
// Top level of the Ising energy monitor
// Config, spin and weight channels each pass through a register pipe
// The sequencer paces weight beats into parallel row calculators
// The accumulator total leaves on the energy channel and is then cleared

`default_nettype none

module energy_monitor
    import energy_pkg::*;
(
    input  logic         clk_i,
    input  logic         arst_n_i,

    input  logic         config_valid_i,
    input  spin_idx_t    config_i,
    output logic         config_ready_o,

    input  logic         spin_valid_i,
    input  spin_vec_t    spin_i,
    output logic         spin_ready_o,

    input  logic         weight_valid_i,
    input  weight_beat_t weight_i,
    output logic         weight_ready_o,

    output logic         energy_valid_o,
    output energy_t      energy_o,
    input  logic         energy_ready_i
);

    // Pipe outputs toward the sequencer
    logic         cfg_valid;
    spin_idx_t    cfg_data;
    logic         cfg_ready;
    logic         spin_valid;
    spin_vec_t    spin_data;
    logic         spin_ready;
    logic         wgt_valid;
    weight_beat_t wgt_data;
    logic         wgt_ready;

    // Sequencer to datapath
    logic                   beat_fire;
    logic                   last_beat;
    logic [PARALLELISM-1:0] cur_spin;
    spin_vec_t              spin_cache;

    // Pulses aligned with the registered row energies
    logic beat_vld_q;
    logic beat_last_q;

    local_energy_t [PARALLELISM-1:0] row_energy;
    energy_t                         total;
    logic                            done;
    logic                            energy_fire;

    bp_pipe #(
        .payload_t(spin_idx_t),
        .PIPES    (PIPES_INTF)
    ) config_pipe_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .valid_i (config_valid_i),
        .data_i  (config_i),
        .ready_o (config_ready_o),
        .valid_o (cfg_valid),
        .data_o  (cfg_data),
        .ready_i (cfg_ready)
    );

    bp_pipe #(
        .payload_t(spin_vec_t),
        .PIPES    (PIPES_INTF)
    ) spin_pipe_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .valid_i (spin_valid_i),
        .data_i  (spin_i),
        .ready_o (spin_ready_o),
        .valid_o (spin_valid),
        .data_o  (spin_data),
        .ready_i (spin_ready)
    );

    bp_pipe #(
        .payload_t(weight_beat_t),
        .PIPES    (PIPES_INTF)
    ) weight_pipe_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .valid_i (weight_valid_i),
        .data_i  (weight_i),
        .ready_o (weight_ready_o),
        .valid_o (wgt_valid),
        .data_o  (wgt_data),
        .ready_i (wgt_ready)
    );

    row_sequencer row_sequencer_i (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .config_valid_i(cfg_valid),
        .config_i      (cfg_data),
        .config_ready_o(cfg_ready),
        .spin_valid_i  (spin_valid),
        .spin_i        (spin_data),
        .spin_ready_o  (spin_ready),
        .weight_valid_i(wgt_valid),
        .weight_ready_o(wgt_ready),
        .done_i        (done),
        .energy_ready_i(energy_ready_i),
        .beat_fire_o   (beat_fire),
        .last_beat_o   (last_beat),
        .cur_spin_o    (cur_spin),
        .spin_cache_o  (spin_cache)
    );

    // One calculator per row of the beat
    for (genvar g = 0; g < PARALLELISM; g++) begin : g_row
        partial_energy_calc partial_energy_calc_i (
            .clk_i     (clk_i),
            .arst_n_i  (arst_n_i),
            .fire_i    (beat_fire),
            .spin_vec_i(spin_cache),
            .cur_spin_i(cur_spin[g]),
            .row_i     (wgt_data[g]),
            .energy_o  (row_energy[g])
        );
    end

    // Match the single register of the row stage
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            beat_vld_q  <= 1'b0;
            beat_last_q <= 1'b0;
        end else begin
            beat_vld_q  <= beat_fire;
            beat_last_q <= last_beat;
        end
    end

    // Output handshake clears the total
    assign energy_fire = done && energy_ready_i;

    energy_accumulator energy_accumulator_i (
        .clk_i   (clk_i),
        .arst_n_i(arst_n_i),
        .valid_i (beat_vld_q),
        .last_i  (beat_last_q),
        .local_i (row_energy),
        .clear_i (energy_fire),
        .total_o (total),
        .done_o  (done)
    );

    // Total stays put while the consumer stalls
    assign energy_valid_o = done;
    assign energy_o       = total;

endmodule

`default_nettype wire

//--- logic/energy_accumulator.sv
// Running total of the row energies of one job
// Adds the parallel rows of a beat each time valid_i is high
// done_o marks the total complete and holds until clear_i

`default_nettype none

module energy_accumulator
    import energy_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          valid_i,
    input  logic                          last_i,
    input  local_energy_t [PARALLELISM-1:0] local_i,
    input  logic                          clear_i,
    output energy_t                       total_o,
    output logic                          done_o
);

    energy_t group_sum;
    energy_t total_q;
    logic    done_q;

    // Row energies of one beat, sign-extended to the total width
    always_comb begin
        group_sum = '0;
        for (int p = 0; p < PARALLELISM; p++) begin
            group_sum = group_sum + energy_t'($signed(local_i[p]));
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            total_q <= '0;
            done_q  <= 1'b0;
        end else if (clear_i) begin
            // Result taken, ready for the next job
            total_q <= '0;
            done_q  <= 1'b0;
        end else if (valid_i) begin
            total_q <= total_q + group_sum;
            if (last_i) begin
                done_q <= 1'b1;
            end
        end
    end

    assign total_o = total_q;
    assign done_o  = done_q;

endmodule

`default_nettype wire

//--- logic/partial_energy_calc.sv
// Local energy of one coupling row
// Dot product of the row with the spin vector plus the scaled bias
// Sign flipped by the row's own spin, result registered on fire_i

`default_nettype none

module partial_energy_calc
    import energy_pkg::*;
(
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          fire_i,
    input  spin_vec_t     spin_vec_i,
    input  logic          cur_spin_i,
    input  row_beat_t     row_i,
    output local_energy_t energy_o
);

    local_energy_t dot_sum;
    local_energy_t bias_term;
    local_energy_t row_sum;
    local_energy_t energy_q;

    // Sum of J_rj * s_j with s_j as +1 or -1
    always_comb begin
        dot_sum = '0;
        for (int j = 0; j < NUM_SPIN; j++) begin
            if (spin_vec_i[j]) begin
                dot_sum = dot_sum + local_energy_t'($signed(row_i.row[j]));
            end else begin
                dot_sum = dot_sum - local_energy_t'($signed(row_i.row[j]));
            end
        end
    end

    // Scale is unsigned, zero-extended before the signed multiply
    assign bias_term = local_energy_t'($signed(row_i.hbias))
                     * local_energy_t'({1'b0, row_i.hscaling});

    assign row_sum = dot_sum + bias_term;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            energy_q <= '0;
        end else if (fire_i) begin
            // Own spin of 0 means -1
            energy_q <= cur_spin_i ? row_sum : -row_sum;
        end
    end

    assign energy_o = energy_q;

endmodule

`default_nettype wire

//--- logic/row_sequencer.sv
// Job control for the energy monitor
// Takes a start row, caches the spin vector, then paces the weight beats
// Drives all input ready signals from its state and picks the group's spins
// A job ends when the total is handed out on the energy channel

`default_nettype none

module row_sequencer
    import energy_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   config_valid_i,
    input  spin_idx_t              config_i,
    output logic                   config_ready_o,
    input  logic                   spin_valid_i,
    input  spin_vec_t              spin_i,
    output logic                   spin_ready_o,
    input  logic                   weight_valid_i,
    output logic                   weight_ready_o,
    input  logic                   done_i,
    input  logic                   energy_ready_i,
    output logic                   beat_fire_o,
    output logic                   last_beat_o,
    output logic [PARALLELISM-1:0] cur_spin_o,
    output spin_vec_t              spin_cache_o
);

    typedef enum logic [1:0] {
        IDLE,
        LOADED,
        RUN,
        WAIT
    } state_e;

    state_e    state_q;
    state_e    state_d;
    spin_idx_t start_q;
    spin_idx_t cnt_q;
    logic      cfg_seen_q;
    spin_vec_t cache_q;

    logic      cfg_fire;
    logic      spin_fire;
    logic      weight_fire;
    logic      last_group;
    logic      energy_fire;

    // Ready signals follow the state only
    assign config_ready_o = (state_q == IDLE);
    // A new spin vector may restart from the stored start row
    assign spin_ready_o   = (state_q == LOADED) || ((state_q == IDLE) && cfg_seen_q);
    assign weight_ready_o = (state_q == RUN);

    assign cfg_fire    = config_valid_i && config_ready_o;
    assign spin_fire   = spin_valid_i && spin_ready_o;
    assign weight_fire = weight_valid_i && weight_ready_o;
    // Total handed out downstream
    assign energy_fire = done_i && energy_ready_i;

    // Counter sits on the top row group
    assign last_group = (cnt_q == spin_idx_t'(NUM_SPIN - PARALLELISM));

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (spin_fire) begin
                    state_d = RUN;
                end else if (cfg_fire) begin
                    state_d = LOADED;
                end
            end
            LOADED: begin
                if (spin_fire) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (weight_fire && last_group) begin
                    state_d = WAIT;
                end
            end
            WAIT: begin
                if (energy_fire) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            start_q    <= '0;
            cnt_q      <= '0;
            cfg_seen_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (cfg_fire) begin
                start_q    <= config_i;
                cfg_seen_q <= 1'b1;
            end
            // Spin reload wins; same-cycle config supplies the start
            if (spin_fire) begin
                cnt_q <= cfg_fire ? config_i : start_q;
            end else if (cfg_fire) begin
                cnt_q <= config_i;
            end else if (weight_fire) begin
                cnt_q <= cnt_q + spin_idx_t'(PARALLELISM);
            end
        end
    end

    // Spin cache
    always_ff @(posedge clk_i) begin
        if (spin_fire) begin
            cache_q <= spin_i;
        end
    end

    // Little-endian group select
    assign cur_spin_o   = cache_q[cnt_q +: PARALLELISM];
    assign spin_cache_o = cache_q;

    // One pulse per accepted weight beat
    assign beat_fire_o = weight_fire;
    assign last_beat_o = weight_fire && last_group;

endmodule

`default_nettype wire

//--- logic/bp_pipe.sv
// Valid/ready register pipe for any payload type
// Each stage holds a main and a skid register and registers its ready
// A word entering reaches the output PIPES cycles later without stalls
// PIPES of zero turns the pipe into plain wires

`default_nettype none

module bp_pipe #(
    parameter type payload_t = logic [7:0],
    parameter int  PIPES     = 1
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    if (PIPES == 0) begin : g_wire
        assign valid_o = valid_i;
        assign data_o  = data_i;
        assign ready_o = ready_i;
    end else begin : g_chain
        // Index k is the input side of stage k, PIPES is the pipe output
        logic [PIPES:0] chain_v;
        logic [PIPES:0] chain_r;
        payload_t       chain_d [PIPES+1];

        assign chain_v[0]     = valid_i;
        assign chain_d[0]     = data_i;
        assign ready_o        = chain_r[0];
        assign valid_o        = chain_v[PIPES];
        assign data_o         = chain_d[PIPES];
        assign chain_r[PIPES] = ready_i;

        for (genvar k = 0; k < PIPES; k++) begin : g_stage
            logic     rdy_q;
            logic     main_v_q;
            logic     skid_v_q;
            payload_t main_d_q;
            payload_t skid_d_q;
            logic     take_in;
            logic     main_free;
            logic     skid_load;

            // Word arrives while this stage advertised room
            assign take_in   = chain_v[k] && rdy_q;
            // Main slot empties or hands its word on
            assign main_free = !main_v_q || chain_r[k+1];
            // Park the incoming word when main cannot take it directly
            assign skid_load = take_in && (!main_free || skid_v_q);

            always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    rdy_q    <= 1'b0;
                    main_v_q <= 1'b0;
                    skid_v_q <= 1'b0;
                end else begin
                    // Stall travels back one stage per cycle
                    rdy_q <= chain_r[k+1];
                    if (main_free) begin
                        main_v_q <= skid_v_q || take_in;
                    end
                    skid_v_q <= skid_load || (skid_v_q && !main_free);
                end
            end

            // Payload registers
            always_ff @(posedge clk_i) begin
                if (main_free && (skid_v_q || take_in)) begin
                    // Older skid word goes first to keep order
                    main_d_q <= skid_v_q ? skid_d_q : chain_d[k];
                end
                if (skid_load) begin
                    skid_d_q <= chain_d[k];
                end
            end

            assign chain_r[k]   = rdy_q;
            assign chain_v[k+1] = main_v_q;
            assign chain_d[k+1] = main_d_q;
        end
    end

endmodule

`default_nettype wire

//--- logic/energy_pkg.sv
// Shared sizes and types for the Ising energy monitor
// Every RTL block imports this package for its widths and payload types
// Spin bit 1 stands for +1 and spin bit 0 for -1

`default_nettype none

package energy_pkg;

    // Problem size
    localparam int NUM_SPIN = 16;
    // Coupling rows carried by one weight beat, divides NUM_SPIN
    localparam int PARALLELISM = 2;

    // Operand precision
    localparam int BIT_J = 4;
    localparam int BIT_H = 4;
    localparam int SCALING_BIT = 3;

    // Worst row is 16*8 + 8*7 = 184, so 12 bits is ample
    localparam int LOCAL_ENERGY_BIT = 12;
    // Sixteen rows of at most 184 stay far below 2^19
    localparam int ENERGY_TOTAL_BIT = 20;

    // Row index width
    localparam int SPIN_IDX_BIT = 4;

    // Register stages in each input pipe
    localparam int PIPES_INTF = 1;

    // One bit per spin, little-endian
    typedef logic [NUM_SPIN-1:0] spin_vec_t;

    // Row counter and start index
    typedef logic [SPIN_IDX_BIT-1:0] spin_idx_t;

    // Element j holds the signed coupling J_rj
    typedef logic [NUM_SPIN-1:0][BIT_J-1:0] weight_row_t;

    // Everything one row needs
    typedef struct packed {
        weight_row_t                  row;
        logic signed [BIT_H-1:0]      hbias;
        logic        [SCALING_BIT-1:0] hscaling;
    } row_beat_t;

    // Element 0 is the lowest row of the group
    typedef row_beat_t [PARALLELISM-1:0] weight_beat_t;

    // Per-row energy and running total
    typedef logic signed [LOCAL_ENERGY_BIT-1:0] local_energy_t;
    typedef logic signed [ENERGY_TOTAL_BIT-1:0] energy_t;

endpackage

`default_nettype wire
